/* hdl/ip_hdr_consts.svh */
`ifndef IP_HDR_CONSTS_SVH
`define IP_HDR_CONSTS_SVH

// Fixed IPv4 header geometry, no options
`define IP_HDR_BYTES 20
`define IP_HDR_WORDS 10

// Version 4, IHL 5, TOS 0
`define IP_VER_IHL_TOS 16'h4500
// Identification kept constant
`define IP_IDENT 16'hA86C
// DF set, fragment offset zero
`define IP_FLAGS_FRAG 16'h4000
`define IP_TTL 8'h40

// Position of the checksum among the ten header words
`define IP_CSUM_WORD 5

`endif

/* hdl/ip_hdr_pkg.sv */
`default_nettype none

package ip_hdr_pkg;

	// Single header octet on the output stream
	typedef logic [7:0] hdr_byte_t;
	// Header word, also length and checksum width
	typedef logic [15:0] hdr_word_t;
	typedef logic [31:0] ipv4_addr_t;
	// Counts words while summing, bytes while sending
	typedef logic [4:0] hdr_idx_t;

	// Capture, checksum pass, byte output
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SUM,
		ST_SEND
	} hdr_state_t;

endpackage

`default_nettype wire

/* hdl/hdr_ctrl_fsm.sv */
`default_nettype none

module hdr_ctrl_fsm
	import ip_hdr_pkg::*;
(
	input  wire        clk,
	input  wire        rst_i,
	input  wire        len_tvalid_i,
	input  wire        hdr_tready_i,
	input  wire        last_i,
	output hdr_state_t state_o,
	output logic       len_tready_o,
	output logic       capture_o,
	output logic       start_o,
	output logic       step_o,
	output logic       hdr_tvalid_o
);

	hdr_state_t state_q;
	hdr_state_t state_d;

	// Length accepted only while no header is in flight
	assign len_tready_o = (state_q == ST_IDLE);
	assign capture_o    = len_tready_o & len_tvalid_i;
	assign hdr_tvalid_o = (state_q == ST_SEND);

	// Counter restarts on capture and again when summing ends
	assign start_o = capture_o | ((state_q == ST_SUM) & last_i);

	// One word per cycle while summing, one byte per handshake while sending
	assign step_o = (state_q == ST_SUM) | (hdr_tvalid_o & hdr_tready_i);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (capture_o) begin
					state_d = ST_SUM;
				end
			end
			ST_SUM: begin
				// Word 9 added on this edge, checksum ready next cycle
				if (last_i) begin
					state_d = ST_SEND;
				end
			end
			ST_SEND: begin
				// Leave on the handshake of byte 19
				if (hdr_tready_i && last_i) begin
					state_d = ST_IDLE;
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign state_o = state_q;

endmodule

`default_nettype wire

/* hdl/hdr_index_counter.sv */
`default_nettype none

`include "ip_hdr_consts.svh"

module hdr_index_counter
	import ip_hdr_pkg::*;
(
	input  wire        clk,
	input  wire        rst_i,
	input  wire        start_i,
	input  wire        step_i,
	input  hdr_state_t state_i,
	output hdr_idx_t   idx_o,
	output logic       last_o
);

	hdr_idx_t idx_q;

	// Start wins over step when both land on one edge
	always_ff @(posedge clk) begin
		if (rst_i || start_i) begin
			idx_q <= '0;
		end else if (step_i) begin
			idx_q <= idx_q + hdr_idx_t'(1);
		end
	end

	// Terminal value depends on phase
	always_comb begin
		case (state_i)
			ST_SUM:  last_o = (idx_q == hdr_idx_t'(`IP_HDR_WORDS - 1));
			ST_SEND: last_o = (idx_q == hdr_idx_t'(`IP_HDR_BYTES - 1));
			default: last_o = 1'b0;
		endcase
	end

	assign idx_o = idx_q;

endmodule

`default_nettype wire

/* hdl/hdr_field_mux.sv */
`default_nettype none

`include "ip_hdr_consts.svh"

module hdr_field_mux
	import ip_hdr_pkg::*;
(
	input  wire        clk,
	input  wire        rst_i,
	input  wire        capture_i,
	input  hdr_word_t  len_i,
	input  ipv4_addr_t src_ip_i,
	input  ipv4_addr_t dest_ip_i,
	input  hdr_byte_t  protocol_i,
	input  hdr_state_t state_i,
	input  hdr_idx_t   idx_i,
	input  hdr_word_t  csum_i,
	output hdr_word_t  word_o,
	output hdr_byte_t  byte_o
);

	// Header words in network order
	typedef enum logic [3:0] {
		F_VER_TOS,
		F_TOT_LEN,
		F_IDENT,
		F_FLAGS,
		F_TTL_PROTO,
		F_CSUM = 4'(`IP_CSUM_WORD),
		F_SRC_HI,
		F_SRC_LO,
		F_DST_HI,
		F_DST_LO
	} field_t;

	hdr_word_t  tot_len_q;
	ipv4_addr_t src_q;
	ipv4_addr_t dest_q;
	hdr_byte_t  proto_q;
	hdr_idx_t   word_idx;
	field_t     field;

	// Snapshot of the packet fields, inputs are free to move afterwards
	always_ff @(posedge clk) begin
		if (rst_i) begin
			tot_len_q <= '0;
			src_q     <= '0;
			dest_q    <= '0;
			proto_q   <= '0;
		end else if (capture_i) begin
			// Wraps modulo 2^16
			tot_len_q <= len_i + hdr_word_t'(`IP_HDR_BYTES);
			src_q     <= src_ip_i;
			dest_q    <= dest_ip_i;
			proto_q   <= protocol_i;
		end
	end

	// Byte index maps to word index by dropping the lowest bit
	assign word_idx = (state_i == ST_SEND) ? (idx_i >> 1) : idx_i;
	assign field    = field_t'(word_idx[3:0]);

	always_comb begin
		case (field)
			F_VER_TOS:   word_o = `IP_VER_IHL_TOS;
			F_TOT_LEN:   word_o = tot_len_q;
			F_IDENT:     word_o = `IP_IDENT;
			F_FLAGS:     word_o = `IP_FLAGS_FRAG;
			F_TTL_PROTO: word_o = {`IP_TTL, proto_q};
			// Zero while summing, final value while sending
			F_CSUM:      word_o = (state_i == ST_SEND) ? csum_i : '0;
			F_SRC_HI:    word_o = src_q[31:16];
			F_SRC_LO:    word_o = src_q[15:0];
			F_DST_HI:    word_o = dest_q[31:16];
			F_DST_LO:    word_o = dest_q[15:0];
			default:     word_o = '0;
		endcase
	end

	// Even byte index is the high octet
	assign byte_o = idx_i[0] ? word_o[7:0] : word_o[15:8];

endmodule

`default_nettype wire

/* hdl/ones_comp_sum.sv */
`default_nettype none

module ones_comp_sum
	import ip_hdr_pkg::*;
(
	input  wire       clk,
	input  wire       rst_i,
	input  wire       clear_i,
	input  wire       add_i,
	input  hdr_word_t word_i,
	output hdr_word_t csum_o
);

	hdr_word_t   acc_q;
	logic [16:0] raw_sum;
	hdr_word_t   folded;

	// Carry out of bit 15 wraps back into bit 0
	assign raw_sum = {1'b0, acc_q} + {1'b0, word_i};
	// Cannot carry again, low half is at most 0xFFFE when carry is set
	assign folded  = raw_sum[15:0] + hdr_word_t'(raw_sum[16]);

	always_ff @(posedge clk) begin
		if (rst_i || clear_i) begin
			acc_q <= '0;
		end else if (add_i) begin
			acc_q <= folded;
		end
	end

	// Checksum field is the complement of the running sum
	assign csum_o = ~acc_q;

endmodule

`default_nettype wire

/* hdl/ip_header_gen.sv */
`default_nettype none

module ip_header_gen
	import ip_hdr_pkg::*;
(
	input  wire        clk,
	input  wire        rst_i,

	// Payload length stream, fields sampled on the same handshake
	input  wire        len_tvalid_i,
	input  hdr_word_t  len_tdata_i,
	output logic       len_tready_o,
	input  ipv4_addr_t src_ip_i,
	input  ipv4_addr_t dest_ip_i,
	input  hdr_byte_t  protocol_i,

	// Header byte stream
	output hdr_byte_t  hdr_tdata_o,
	output logic       hdr_tvalid_o,
	output logic       hdr_tlast_o,
	input  wire        hdr_tready_i
);

	hdr_state_t state;
	logic       capture;
	logic       start;
	logic       step;
	logic       idx_last;
	logic       sum_add;
	hdr_idx_t   idx;
	hdr_word_t  word;
	hdr_word_t  csum;

	hdr_ctrl_fsm u_ctrl (
		.clk          (clk),
		.rst_i        (rst_i),
		.len_tvalid_i (len_tvalid_i),
		.hdr_tready_i (hdr_tready_i),
		.last_i       (idx_last),
		.state_o      (state),
		.len_tready_o (len_tready_o),
		.capture_o    (capture),
		.start_o      (start),
		.step_o       (step),
		.hdr_tvalid_o (hdr_tvalid_o)
	);

	hdr_index_counter u_idx (
		.clk     (clk),
		.rst_i   (rst_i),
		.start_i (start),
		.step_i  (step),
		.state_i (state),
		.idx_o   (idx),
		.last_o  (idx_last)
	);

	hdr_field_mux u_fields (
		.clk        (clk),
		.rst_i      (rst_i),
		.capture_i  (capture),
		.len_i      (len_tdata_i),
		.src_ip_i   (src_ip_i),
		.dest_ip_i  (dest_ip_i),
		.protocol_i (protocol_i),
		.state_i    (state),
		.idx_i      (idx),
		.csum_i     (csum),
		.word_o     (word),
		.byte_o     (hdr_tdata_o)
	);

	// Accumulate only in the summing pass
	assign sum_add = step & (state == ST_SUM);

	// Capture clears the sum, the start at the end of summing must not
	ones_comp_sum u_csum (
		.clk     (clk),
		.rst_i   (rst_i),
		.clear_i (capture),
		.add_i   (sum_add),
		.word_i  (word),
		.csum_o  (csum)
	);

	// Counter terminal flag marks byte 19 only while sending
	assign hdr_tlast_o = idx_last & hdr_tvalid_o;

endmodule

`default_nettype wire

/* dv/ip_header_gen_assertions.sv */
`default_nettype none

`include "ip_hdr_consts.svh"

module ip_header_gen_assertions
	import ip_hdr_pkg::*;
(
	input wire       clk,
	input wire       rst_i,
	input wire       len_tvalid_i,
	input wire       len_tready_o,
	input wire       hdr_tvalid_o,
	input wire       hdr_tlast_o,
	input wire       hdr_tready_i,
	input hdr_byte_t hdr_tdata_o
);

	int       fail_count = 0;
	logic     busy_q;
	hdr_idx_t beats_q;

	// Header in flight from the length handshake up to the last byte handshake
	always_ff @(posedge clk) begin
		if (rst_i) begin
			busy_q  <= 1'b0;
			beats_q <= '0;
		end else begin
			if (len_tvalid_i && len_tready_o) begin
				busy_q <= 1'b1;
			end
			// Bytes transferred so far in this header
			if (hdr_tvalid_o && hdr_tready_i) begin
				if (hdr_tlast_o) begin
					busy_q  <= 1'b0;
					beats_q <= '0;
				end else begin
					beats_q <= beats_q + hdr_idx_t'(1);
				end
			end
		end
	end

	// Stalled byte keeps valid, data and last until the handshake
	a_hold_under_stall: assert property (@(posedge clk) disable iff (rst_i)
		hdr_tvalid_o && !hdr_tready_i |=>
		hdr_tvalid_o && $stable(hdr_tdata_o) && $stable(hdr_tlast_o))
	else begin
		$error("output stream changed while stalled");
		fail_count++;
	end

	// Last marks a valid byte and only the final byte of the header
	a_last_with_valid: assert property (@(posedge clk) disable iff (rst_i)
		hdr_tlast_o |-> hdr_tvalid_o && (beats_q == hdr_idx_t'(`IP_HDR_BYTES - 1)))
	else begin
		$error("hdr_tlast_o high off the final valid byte");
		fail_count++;
	end

	// No new length while a header is in flight
	a_ready_excl_valid: assert property (@(posedge clk) disable iff (rst_i)
		(busy_q || hdr_tvalid_o) |-> !len_tready_o)
	else begin
		$error("len_tready_o high while a header is in flight");
		fail_count++;
	end

endmodule

bind ip_header_gen ip_header_gen_assertions u_assertions (
	.clk          (clk),
	.rst_i        (rst_i),
	.len_tvalid_i (len_tvalid_i),
	.len_tready_o (len_tready_o),
	.hdr_tvalid_o (hdr_tvalid_o),
	.hdr_tlast_o  (hdr_tlast_o),
	.hdr_tready_i (hdr_tready_i),
	.hdr_tdata_o  (hdr_tdata_o)
);

`default_nettype wire

/* dv/tb_ip_header_gen.sv */
`default_nettype none

`include "ip_hdr_consts.svh"

module tb_ip_header_gen
	import ip_hdr_pkg::*;
();

	// 5 tests, up to 4 packets each, 80 cycles per packet at most
	localparam int TIMEOUT_CYCLES  = 5 * 4 * 80;
	localparam int HANDSHAKE_LIMIT = 80;

	logic       clk;
	logic       rst_i;
	logic       len_tvalid_i;
	hdr_word_t  len_tdata_i;
	logic       len_tready_o;
	ipv4_addr_t src_ip_i;
	ipv4_addr_t dest_ip_i;
	hdr_byte_t  protocol_i;
	hdr_byte_t  hdr_tdata_o;
	logic       hdr_tvalid_o;
	logic       hdr_tlast_o;
	logic       hdr_tready_i;

	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	logic [31:0] lfsr = 32'hbb2abb1f;
	hdr_word_t   exp_words [`IP_HDR_WORDS];
	hdr_byte_t   rx_bytes [`IP_HDR_BYTES];

	ip_header_gen uut (
		.clk          (clk),
		.rst_i        (rst_i),
		.len_tvalid_i (len_tvalid_i),
		.len_tdata_i  (len_tdata_i),
		.len_tready_o (len_tready_o),
		.src_ip_i     (src_ip_i),
		.dest_ip_i    (dest_ip_i),
		.protocol_i   (protocol_i),
		.hdr_tdata_o  (hdr_tdata_o),
		.hdr_tvalid_o (hdr_tvalid_o),
		.hdr_tlast_o  (hdr_tlast_o),
		.hdr_tready_i (hdr_tready_i)
	);

	always #10 clk = ~clk;

	// Watchdog on total run length
	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks: %0d, errors: %0d", checks, errors + 1);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Galois LFSR stepped once per bit
	function automatic logic next_bit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) begin
			lfsr = lfsr ^ 32'hD0000001;
		end
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], next_bit()};
		end
		return v;
	endfunction

	// One's-complement add with end-around carry
	function automatic hdr_word_t ones_add(input hdr_word_t a, input hdr_word_t b);
		logic [16:0] s;
		s = {1'b0, a} + {1'b0, b};
		return s[15:0] + hdr_word_t'(s[16]);
	endfunction

	// Expected header words with the checksum summed over a zero slot
	function automatic void build_expected(input hdr_word_t len, input ipv4_addr_t src,
		input ipv4_addr_t dst, input hdr_byte_t proto);
		hdr_word_t sum;
		exp_words[0] = 16'h4500;
		exp_words[1] = len + 16'd20;
		exp_words[2] = 16'hA86C;
		exp_words[3] = 16'h4000;
		exp_words[4] = {8'h40, proto};
		exp_words[5] = 16'h0000;
		exp_words[6] = src[31:16];
		exp_words[7] = src[15:0];
		exp_words[8] = dst[31:16];
		exp_words[9] = dst[15:0];
		sum = '0;
		for (int i = 0; i < `IP_HDR_WORDS; i++) begin
			sum = ones_add(sum, exp_words[i]);
		end
		exp_words[5] = ~sum;
	endfunction

	task automatic check_byte(input string name, input hdr_byte_t got, input hdr_byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got 0x%02h, expected 0x%02h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_word(input string name, input hdr_word_t got, input hdr_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got 0x%04h, expected 0x%04h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got 0x%01h, expected 0x%01h at %0t", name, got, exp, $time);
		end
	endtask

	// Offer one length, wait for the transfer edge, then scramble the inputs
	task automatic present_length(input hdr_word_t len, input ipv4_addr_t src,
		input ipv4_addr_t dst, input hdr_byte_t proto, input logic expect_ready);
		int waited;
		waited = 0;
		len_tvalid_i = 1'b1;
		len_tdata_i  = len;
		src_ip_i     = src;
		dest_ip_i    = dst;
		protocol_i   = proto;
		@(negedge clk);
		if (expect_ready) begin
			check_flag("len_tready_o", len_tready_o, 1'b1);
		end
		while (!len_tready_o && waited < HANDSHAKE_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!len_tready_o) begin
			errors++;
			$display("ERROR: length not accepted within %0d cycles", HANDSHAKE_LIMIT);
		end
		@(posedge clk);
		#2;
		// Fields must already be latched
		len_tvalid_i = 1'b0;
		len_tdata_i  = hdr_word_t'(rand_bits(16));
		src_ip_i     = rand_bits(32);
		dest_ip_i    = rand_bits(32);
		protocol_i   = hdr_byte_t'(rand_bits(8));
	endtask

	// Follows one header from the transfer edge to its last byte
	task automatic collect_header(input logic stall, input logic check_latency);
		int        edges;
		int        nbytes;
		hdr_byte_t exp_b;
		hdr_word_t sum;
		edges = 0;
		nbytes = 0;
		sum = '0;
		@(negedge clk);
		// Summing pass with nothing on the output yet
		while (!hdr_tvalid_o && edges < HANDSHAKE_LIMIT) begin
			check_flag("len_tready_o", len_tready_o, 1'b0);
			@(posedge clk);
			#2;
			hdr_tready_i = stall ? next_bit() : 1'b1;
			edges++;
			@(negedge clk);
		end
		if (!hdr_tvalid_o) begin
			errors++;
			$display("ERROR: no header byte within %0d cycles of the length", HANDSHAKE_LIMIT);
			@(posedge clk);
			#2;
			return;
		end
		if (check_latency) begin
			check_word("hdr_tvalid_o latency", hdr_word_t'(edges), 16'd10);
		end
		while (nbytes < `IP_HDR_BYTES) begin
			// Even byte index carries the high octet
			exp_b = nbytes[0] ? exp_words[nbytes / 2][7:0] : exp_words[nbytes / 2][15:8];
			check_flag("hdr_tvalid_o", hdr_tvalid_o, 1'b1);
			check_flag("len_tready_o", len_tready_o, 1'b0);
			check_byte("hdr_tdata_o", hdr_tdata_o, exp_b);
			check_flag("hdr_tlast_o", hdr_tlast_o, nbytes == `IP_HDR_BYTES - 1);
			if (hdr_tready_i) begin
				rx_bytes[nbytes] = hdr_tdata_o;
				nbytes++;
			end
			@(posedge clk);
			#2;
			hdr_tready_i = stall ? next_bit() : 1'b1;
			if (nbytes < `IP_HDR_BYTES) begin
				@(negedge clk);
			end
		end
		for (int i = 0; i < `IP_HDR_WORDS; i++) begin
			sum = ones_add(sum, {rx_bytes[2 * i], rx_bytes[2 * i + 1]});
		end
		check_word("total length", {rx_bytes[2], rx_bytes[3]}, exp_words[1]);
		check_word("checksum", {rx_bytes[10], rx_bytes[11]}, exp_words[`IP_CSUM_WORD]);
		// Whole header including checksum sums to all ones
		check_word("header ones sum", sum, 16'hFFFF);
	endtask

	task automatic run_packet(input hdr_word_t len, input ipv4_addr_t src, input ipv4_addr_t dst,
		input hdr_byte_t proto, input logic stall, input logic check_latency,
		input logic expect_ready);
		build_expected(len, src, dst, proto);
		present_length(len, src, dst, proto, expect_ready);
		collect_header(stall, check_latency);
	endtask

	task automatic check_after_reset();
		repeat (5) @(posedge clk);
		#2;
		rst_i = 1'b0;
		@(negedge clk);
		check_flag("hdr_tvalid_o", hdr_tvalid_o, 1'b0);
		check_flag("hdr_tlast_o", hdr_tlast_o, 1'b0);
		check_flag("len_tready_o", len_tready_o, 1'b1);
		@(posedge clk);
		#2;
		hdr_tready_i = 1'b1;
	endtask

	task automatic send_single_header();
		run_packet(16'h0100, 32'hC0A80001, 32'hC0A800C7, 8'h11, 1'b0, 1'b1, 1'b1);
	endtask

	task automatic stress_backpressure();
		for (int p = 0; p < 4; p++) begin
			run_packet(hdr_word_t'(rand_bits(16)), rand_bits(32), rand_bits(32),
				hdr_byte_t'(rand_bits(8)), 1'b1, 1'b0, 1'b0);
		end
		hdr_tready_i = 1'b1;
	endtask

	// Next length offered on the cycle after each last byte
	task automatic stream_back_to_back();
		for (int p = 0; p < 4; p++) begin
			run_packet(hdr_word_t'(rand_bits(16)), rand_bits(32), rand_bits(32),
				hdr_byte_t'(rand_bits(8)), 1'b0, 1'b1, 1'b1);
		end
	endtask

	// Total length wraps past 0xFFFF
	task automatic sweep_edge_lengths();
		run_packet(16'd0, 32'h0A000001, 32'h0A0000FE, 8'h06, 1'b0, 1'b1, 1'b1);
		run_packet(16'd65515, 32'hFFFFFFFF, 32'hFFFFFFFF, 8'hFF, 1'b0, 1'b1, 1'b1);
		run_packet(16'd65535, 32'h00000000, 32'h00000000, 8'h00, 1'b0, 1'b1, 1'b1);
	endtask

	initial begin
		clk          = 1'b0;
		rst_i        = 1'b1;
		len_tvalid_i = 1'b0;
		len_tdata_i  = '0;
		src_ip_i     = '0;
		dest_ip_i    = '0;
		protocol_i   = '0;
		hdr_tready_i = 1'b0;
		check_after_reset();
		send_single_header();
		stress_backpressure();
		stream_back_to_back();
		sweep_edge_lengths();
		errors += uut.u_assertions.fail_count;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/ip_hdr_pkg.sv
hdl/hdr_ctrl_fsm.sv
hdl/hdr_index_counter.sv
hdl/hdr_field_mux.sv
hdl/ones_comp_sum.sv
hdl/ip_header_gen.sv
dv/ip_header_gen_assertions.sv
dv/tb_ip_header_gen.sv
